//--- verilog/mm_ram_macros.svh
// memory size, address map, status codes and timer interrupt id
// for the memory-mapped RAM wrapper
`ifndef MM_RAM_MACROS_SVH
`define MM_RAM_MACROS_SVH

// byte address width of the shared RAM
`define MM_RAM_ADDR_WIDTH 16

// width of one instruction fetch line
`define MM_INSTR_WIDTH 128

// pseudo peripheral address map
`define MM_CONSOLE_ADDR    32'h1000_0000
`define MM_STATUS_ADDR     32'h2000_0000
`define MM_EXIT_ADDR       32'h2000_0004
`define MM_TIMER_MASK_ADDR 32'h1500_0000
`define MM_TIMER_CNT_ADDR  32'h1500_0004
`define MM_TIMER_READ_ADDR 32'h1500_1000

// values written to the status register
`define MM_PASS_CODE 32'd123456789
`define MM_FAIL_CODE 32'd1

// mask bit and acknowledge id of the timer interrupt
`define MM_TIMER_IRQ_ID 7

`endif

//--- verilog/mem_bus_pkg.sv
// request structs for the core data bus and the RAM data port
`include "mm_ram_macros.svh"

`default_nettype none

package mem_bus_pkg;

    // one data request as issued by the core
    typedef struct packed {
        logic [31:0] addr;
        logic        we;
        logic [3:0]  be;
        logic [31:0] wdata;
    } data_req_t;

    // data port request after decode, address cut to the RAM size
    typedef struct packed {
        logic [`MM_RAM_ADDR_WIDTH-1:0] addr;
        logic                          we;
        logic [3:0]                    be;
        logic [31:0]                   wdata;
    } ram_port_t;

endpackage

`default_nettype wire

//--- verilog/periph_pkg.sv
// decoded target and peripheral register select enums
`default_nettype none

package periph_pkg;

    // where a data request ends up
    typedef enum logic [1:0] {
        TGT_RAM    = 2'd0,
        TGT_PERIPH = 2'd1,
        TGT_ERR    = 2'd2
    } target_e;

    // addressed pseudo peripheral register
    typedef enum logic [2:0] {
        SEL_NONE       = 3'd0,
        SEL_CONSOLE    = 3'd1,
        SEL_STATUS     = 3'd2,
        SEL_EXIT       = 3'd3,
        SEL_TIMER_MASK = 3'd4,
        SEL_TIMER_CNT  = 3'd5,
        SEL_TIMER_READ = 3'd6
    } periph_sel_e;

endpackage

`default_nettype wire

//--- verilog/dp_ram.sv
// dual-port byte RAM, wide instruction read port and byte-enabled data port
`timescale 1ns/10ps
`default_nettype none

module dp_ram #(
    parameter int ADDR_WIDTH  = 16,
    parameter int INSTR_WIDTH = 128
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,

    input  logic                   instr_req_i,
    input  logic [ADDR_WIDTH-1:0]  instr_addr_i,
    output logic                   instr_gnt_o,
    output logic                   instr_rvalid_o,
    output logic [INSTR_WIDTH-1:0] instr_rdata_o,

    input  logic                   ram_req_i,
    input  mem_bus_pkg::ram_port_t ram_port_i,
    output logic [31:0]            ram_rdata_o
);

    localparam int NUM_BYTES   = 2 ** ADDR_WIDTH;
    localparam int INSTR_BYTES = INSTR_WIDTH / 8;

    logic [7:0]            mem [NUM_BYTES];
    logic [ADDR_WIDTH-1:0] instr_base;
    logic [ADDR_WIDTH-1:0] data_base;

    // both ports work on word-aligned addresses
    assign instr_base = {instr_addr_i[ADDR_WIDTH-1:2], 2'b00};
    assign data_base  = {ram_port_i.addr[ADDR_WIDTH-1:2], 2'b00};

    // fetch is always accepted
    assign instr_gnt_o = instr_req_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_o <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
        end
    end

    // line fetch, byte 0 in the low bits, wraps at the top of memory
    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            for (int i = 0; i < INSTR_BYTES; i++) begin
                instr_rdata_o[8*i +: 8] <= mem[instr_base + ADDR_WIDTH'(i)];
            end
        end
    end

    // data port, read returns the contents from before a same-cycle write
    always_ff @(posedge clk_i) begin
        if (ram_req_i) begin
            for (int i = 0; i < 4; i++) begin
                ram_rdata_o[8*i +: 8] <= mem[data_base + ADDR_WIDTH'(i)];
                if (ram_port_i.we && ram_port_i.be[i]) begin
                    mem[data_base + ADDR_WIDTH'(i)] <= ram_port_i.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/data_addr_decoder.sv
// data request decode into target, peripheral select and RAM port request
`include "mm_ram_macros.svh"

`timescale 1ns/10ps
`default_nettype none

module data_addr_decoder (
    input  logic                     data_req_i,
    input  mem_bus_pkg::data_req_t   data_pkt_i,
    output periph_pkg::target_e      target_o,
    output logic                     ram_req_o,
    output mem_bus_pkg::ram_port_t   ram_port_o,
    output logic                     periph_we_o,
    output periph_pkg::periph_sel_e  periph_sel_o
);

    import periph_pkg::*;

    logic in_ram;

    // anything with zero upper address bits lies inside the RAM
    assign in_ram = (data_pkt_i.addr[31:`MM_RAM_ADDR_WIDTH] == '0);

    // the RAM only sees the enable, payload is passed as is
    always_comb begin
        ram_port_o.addr  = data_pkt_i.addr[`MM_RAM_ADDR_WIDTH-1:0];
        ram_port_o.we    = data_pkt_i.we;
        ram_port_o.be    = data_pkt_i.be;
        ram_port_o.wdata = data_pkt_i.wdata;
    end

    always_comb begin
        target_o     = TGT_ERR;
        ram_req_o    = 1'b0;
        periph_we_o  = 1'b0;
        periph_sel_o = SEL_NONE;

        if (data_req_i) begin
            if (in_ram) begin
                target_o  = TGT_RAM;
                ram_req_o = 1'b1;
            end else if (data_pkt_i.we) begin
                case (data_pkt_i.addr)
                    `MM_CONSOLE_ADDR:    periph_sel_o = SEL_CONSOLE;
                    `MM_STATUS_ADDR:     periph_sel_o = SEL_STATUS;
                    `MM_EXIT_ADDR:       periph_sel_o = SEL_EXIT;
                    `MM_TIMER_MASK_ADDR: periph_sel_o = SEL_TIMER_MASK;
                    `MM_TIMER_CNT_ADDR:  periph_sel_o = SEL_TIMER_CNT;
                    default:             periph_sel_o = SEL_NONE;
                endcase
            end else if (data_pkt_i.addr == `MM_TIMER_READ_ADDR) begin
                // only readable peripheral address
                periph_sel_o = SEL_TIMER_READ;
            end

            if (periph_sel_o != SEL_NONE) begin
                target_o    = TGT_PERIPH;
                periph_we_o = data_pkt_i.we;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/periph_regs.sv
// console, status, exit and timer pseudo peripherals
// with the timer interrupt
`include "mm_ram_macros.svh"

`timescale 1ns/10ps
`default_nettype none

module periph_regs (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    input  logic                    periph_we_i,
    input  periph_pkg::periph_sel_e periph_sel_i,
    input  logic [31:0]             wdata_i,
    input  logic                    irq_ack_i,
    input  logic [4:0]              irq_id_i,
    output logic [31:0]             periph_rdata_o,

    output logic                    console_valid_o,
    output logic [7:0]              console_char_o,
    output logic                    tests_passed_o,
    output logic                    tests_failed_o,
    output logic                    exit_valid_o,
    output logic [31:0]             exit_value_o,
    output logic                    irq_timer_o
);

    import periph_pkg::*;

    logic        console_we;
    logic        status_we;
    logic        exit_we;
    logic        mask_we;
    logic        cnt_we;
    logic        timer_expire;
    logic [31:0] timer_mask_q;
    logic [31:0] timer_cnt_q;
    logic [31:0] timer_rd_q;

    assign console_we = periph_we_i && (periph_sel_i == SEL_CONSOLE);
    assign status_we  = periph_we_i && (periph_sel_i == SEL_STATUS);
    assign exit_we    = periph_we_i && (periph_sel_i == SEL_EXIT);
    assign mask_we    = periph_we_i && (periph_sel_i == SEL_TIMER_MASK);
    assign cnt_we     = periph_we_i && (periph_sel_i == SEL_TIMER_CNT);

    // count steps from 1 to 0 on this edge
    assign timer_expire = !mask_we && !cnt_we && (timer_cnt_q == 32'd1);

    // one-cycle output pulses
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            console_valid_o <= 1'b0;
            tests_passed_o  <= 1'b0;
            tests_failed_o  <= 1'b0;
            exit_valid_o    <= 1'b0;
        end else begin
            console_valid_o <= console_we;
            tests_passed_o  <= status_we && (wdata_i == `MM_PASS_CODE);
            tests_failed_o  <= status_we && (wdata_i == `MM_FAIL_CODE);
            exit_valid_o    <= exit_we;
        end
    end

    always_ff @(posedge clk_i) begin
        if (console_we) begin
            console_char_o <= wdata_i[7:0];
        end
        if (exit_we) begin
            exit_value_o <= wdata_i;
        end
        // snapshot of the count at the granting edge
        if (periph_sel_i == SEL_TIMER_READ) begin
            timer_rd_q <= timer_cnt_q;
        end
    end

    assign periph_rdata_o = timer_rd_q;

    // timer writes hold off the count-down for that cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            timer_mask_q <= '0;
            timer_cnt_q  <= '0;
        end else if (mask_we) begin
            timer_mask_q <= wdata_i;
        end else if (cnt_we) begin
            timer_cnt_q <= wdata_i;
        end else if (timer_cnt_q != '0) begin
            timer_cnt_q <= timer_cnt_q - 32'd1;
        end
    end

    // acknowledge wins over a new expiry on the same edge
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            irq_timer_o <= 1'b0;
        end else if (irq_ack_i && (irq_id_i == 5'(`MM_TIMER_IRQ_ID))) begin
            irq_timer_o <= 1'b0;
        end else if (timer_expire && timer_mask_q[`MM_TIMER_IRQ_ID]) begin
            irq_timer_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/data_rsp_ctrl.sv
// data port grant and in-order one-cycle response with read-data select
`timescale 1ns/10ps
`default_nettype none

module data_rsp_ctrl (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  logic                data_req_i,
    input  periph_pkg::target_e target_i,
    input  logic [31:0]         ram_rdata_i,
    input  logic [31:0]         periph_rdata_i,

    output logic                data_gnt_o,
    output logic                data_rvalid_o,
    output logic [31:0]         data_rdata_o,
    output logic                data_err_o
);

    import periph_pkg::*;

    logic    rvalid_q;
    target_e target_q;

    // no back-pressure, every request is granted at once
    assign data_gnt_o = data_req_i;

    // fixed latency of one, so a single stage keeps responses in order
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
            target_q <= TGT_ERR;
        end else begin
            rvalid_q <= data_req_i && data_gnt_o;
            if (data_req_i && data_gnt_o) begin
                target_q <= target_i;
            end
        end
    end

    assign data_rvalid_o = rvalid_q;

    always_comb begin
        data_rdata_o = '0;
        data_err_o   = 1'b0;
        if (rvalid_q) begin
            case (target_q)
                TGT_RAM:    data_rdata_o = ram_rdata_i;
                TGT_PERIPH: data_rdata_o = periph_rdata_i;
                default:    data_err_o   = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/mm_ram.sv
// memory-mapped wrapper with shared RAM and pseudo peripherals
// for a small RISC-V core
`include "mm_ram_macros.svh"

`timescale 1ns/10ps
`default_nettype none

module mm_ram (
    input  logic                          clk_i,
    input  logic                          rst_ni,

    input  logic                          instr_req_i,
    input  logic [`MM_RAM_ADDR_WIDTH-1:0] instr_addr_i,
    output logic                          instr_gnt_o,
    output logic                          instr_rvalid_o,
    output logic [`MM_INSTR_WIDTH-1:0]    instr_rdata_o,

    input  logic                          data_req_i,
    input  mem_bus_pkg::data_req_t        data_pkt_i,
    output logic                          data_gnt_o,
    output logic                          data_rvalid_o,
    output logic [31:0]                   data_rdata_o,
    output logic                          data_err_o,

    input  logic                          irq_ack_i,
    input  logic [4:0]                    irq_id_i,
    output logic                          irq_timer_o,

    output logic                          console_valid_o,
    output logic [7:0]                    console_char_o,
    output logic                          tests_passed_o,
    output logic                          tests_failed_o,
    output logic                          exit_valid_o,
    output logic [31:0]                   exit_value_o
);

    import mem_bus_pkg::*;
    import periph_pkg::*;

    target_e     target;
    logic        ram_req;
    ram_port_t   ram_port;
    logic [31:0] ram_rdata;
    logic        periph_we;
    periph_sel_e periph_sel;
    logic [31:0] periph_rdata;

    dp_ram #(
        .ADDR_WIDTH  (`MM_RAM_ADDR_WIDTH),
        .INSTR_WIDTH (`MM_INSTR_WIDTH)
    ) dp_ram_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .ram_req_i      (ram_req),
        .ram_port_i     (ram_port),
        .ram_rdata_o    (ram_rdata)
    );

    data_addr_decoder data_addr_decoder_i (
        .data_req_i   (data_req_i),
        .data_pkt_i   (data_pkt_i),
        .target_o     (target),
        .ram_req_o    (ram_req),
        .ram_port_o   (ram_port),
        .periph_we_o  (periph_we),
        .periph_sel_o (periph_sel)
    );

    periph_regs periph_regs_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .periph_we_i     (periph_we),
        .periph_sel_i    (periph_sel),
        .wdata_i         (data_pkt_i.wdata),
        .irq_ack_i       (irq_ack_i),
        .irq_id_i        (irq_id_i),
        .periph_rdata_o  (periph_rdata),
        .console_valid_o (console_valid_o),
        .console_char_o  (console_char_o),
        .tests_passed_o  (tests_passed_o),
        .tests_failed_o  (tests_failed_o),
        .exit_valid_o    (exit_valid_o),
        .exit_value_o    (exit_value_o),
        .irq_timer_o     (irq_timer_o)
    );

    data_rsp_ctrl data_rsp_ctrl_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .data_req_i     (data_req_i),
        .target_i       (target),
        .ram_rdata_i    (ram_rdata),
        .periph_rdata_i (periph_rdata),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .data_err_o     (data_err_o)
    );

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
// clock and active-low reset generator for the testbench
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // release on a falling edge, away from the active edge
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

`default_nettype wire

//--- dv/tb_mm_ram_tests.svh
// test tasks for RAM access, fetch, back-to-back traffic,
// status/exit/console, timer and unmapped access

task automatic test_ram_access();
    logic [`MM_RAM_ADDR_WIDTH-1:0] a;
    // fill pattern built from the whole address
    for (int w = 0; w < 64; w++) begin
        a = REGION_BASE + `MM_RAM_ADDR_WIDTH'(4 * w);
        issue_req(make_req(32'(a), 1'b1, 4'hf, {~a, a}));
    end
    for (int i = 0; i < 40; i++) begin
        issue_req(make_req(rand_ram_addr(), 1'b1, 4'(rand_bits(4)), rand_bits(32)));
        bus_idle();
    end
    for (int i = 0; i < 40; i++) begin
        issue_req(make_req(rand_ram_addr(), 1'b0, 4'hf, 32'd0));
        bus_idle();
    end
    wait_responses();
    finish_test("ram_access");
endtask

task automatic test_instr_fetch();
    logic [`MM_INSTR_WIDTH-1:0]    line;
    logic [`MM_RAM_ADDR_WIDTH-1:0] a;
    for (int i = 0; i < 16; i++) begin
        a = REGION_BASE + `MM_RAM_ADDR_WIDTH'(rand_bits(5) << 2);
        for (int b = 0; b < 16; b++) begin
            line[8*b +: 8] = ref_mem[a + `MM_RAM_ADDR_WIDTH'(b)];
        end
        @(negedge clk);
        instr_req  = 1'b1;
        instr_addr = a;
        #1;
        check_value("instr_gnt_o", instr_gnt, 1'b1);
        @(negedge clk);
        instr_req = 1'b0;
        check_value("instr_rvalid_o", instr_rvalid, 1'b1);
        check_value("instr_rdata_o", instr_rdata, line);
    end
    finish_test("instr_fetch");
endtask

task automatic test_back_to_back();
    for (int i = 0; i < 24; i++) begin
        case (rand_bits(2))
            0: issue_req(make_req(rand_ram_addr(), 1'b0, 4'hf, 32'd0));
            1: issue_req(make_req(rand_ram_addr(), 1'b1, 4'(rand_bits(4)), rand_bits(32)));
            2: issue_req(make_req(`MM_TIMER_READ_ADDR, 1'b0, 4'hf, 32'd0));
            default: issue_req(make_req(`MM_CONSOLE_ADDR, 1'b1, 4'hf, rand_bits(8)));
        endcase
    end
    bus_idle();
    wait_responses();
    finish_test("back_to_back");
endtask

task automatic test_status_exit_console();
    write_periph(`MM_STATUS_ADDR, `MM_PASS_CODE, 4'b0100);
    write_periph(`MM_STATUS_ADDR, `MM_FAIL_CODE, 4'b0010);
    write_periph(`MM_STATUS_ADDR, 32'd42, 4'b0000);
    write_periph(`MM_EXIT_ADDR, rand_bits(32), 4'b0001);
    write_periph(`MM_CONSOLE_ADDR, 32'h0000_0041, 4'b1000);
    wait_responses();
    finish_test("status_exit_con");
endtask

task automatic test_timer();
    int unsigned rise_edge;
    int          n;
    write_periph(`MM_TIMER_MASK_ADDR, 32'd1 << `MM_TIMER_IRQ_ID, 4'b0000);
    write_periph(`MM_TIMER_CNT_ADDR, 32'd30, 4'b0000);
    rise_edge = tmr_load_edge + tmr_load_val;
    // read-back while counting down
    issue_req(make_req(`MM_TIMER_READ_ADDR, 1'b0, 4'hf, 32'd0));
    bus_idle();
    n = 0;
    while (irq_timer !== 1'b1) begin
        if (n == 100) begin
            abort_run("timer interrupt");
        end
        @(negedge clk);
        n++;
    end
    check_value("irq_timer_o rise edge", edge_cnt, rise_edge);
    @(negedge clk);
    irq_ack = 1'b1;
    irq_id  = `MM_TIMER_IRQ_ID;
    @(negedge clk);
    irq_ack = 1'b0;
    irq_id  = '0;
    check_value("irq_timer_o", irq_timer, 1'b0);
    // masked interrupt must stay low
    write_periph(`MM_TIMER_MASK_ADDR, 32'd0, 4'b0000);
    write_periph(`MM_TIMER_CNT_ADDR, 32'd5, 4'b0000);
    repeat (12) begin
        @(negedge clk);
        check_value("irq_timer_o", irq_timer, 1'b0);
    end
    wait_responses();
    finish_test("timer");
endtask

task automatic test_unmapped();
    issue_req(make_req(32'h0001_0000, 1'b0, 4'hf, 32'd0));
    issue_req(make_req(32'h3000_0000, 1'b1, 4'hf, rand_bits(32)));
    issue_req(make_req(32'h8000_0000 | 32'(REGION_BASE), 1'b1, 4'hf, rand_bits(32)));
    issue_req(make_req(`MM_CONSOLE_ADDR, 1'b0, 4'hf, 32'd0));
    issue_req(make_req(`MM_STATUS_ADDR, 1'b0, 4'hf, 32'd0));
    issue_req(make_req(`MM_TIMER_CNT_ADDR, 1'b0, 4'hf, 32'd0));
    issue_req(make_req(`MM_TIMER_READ_ADDR, 1'b1, 4'hf, 32'd3));
    // region contents must be unchanged
    for (int w = 0; w < 64; w++) begin
        issue_req(make_req(32'(REGION_BASE) + 32'(4 * w), 1'b0, 4'hf, 32'd0));
    end
    bus_idle();
    wait_responses();
    finish_test("unmapped");
endtask

//--- dv/tb_mm_ram.sv
// testbench for the memory-mapped RAM wrapper
// reference model, response checker and test sequencing
`include "mm_ram_macros.svh"

`timescale 1ns/10ps
`default_nettype none

module tb_mm_ram;

    import mem_bus_pkg::*;

    // expected data response and the clock edge that granted it
    typedef struct packed {
        logic        err;
        logic        chk_data;
        logic [31:0] rdata;
        logic [31:0] grant_edge;
    } exp_rsp_t;

    // RAM window used by the tests and fully written before any read
    localparam logic [`MM_RAM_ADDR_WIDTH-1:0] REGION_BASE = 16'h0400;

    logic                          clk;
    logic                          rst_n;
    logic                          instr_req;
    logic [`MM_RAM_ADDR_WIDTH-1:0] instr_addr;
    logic                          instr_gnt;
    logic                          instr_rvalid;
    logic [`MM_INSTR_WIDTH-1:0]    instr_rdata;
    logic                          data_req;
    data_req_t                     data_pkt;
    logic                          data_gnt;
    logic                          data_rvalid;
    logic [31:0]                   data_rdata;
    logic                          data_err;
    logic                          irq_ack;
    logic [4:0]                    irq_id;
    logic                          irq_timer;
    logic                          console_valid;
    logic [7:0]                    console_char;
    logic                          tests_passed;
    logic                          tests_failed;
    logic                          exit_valid;
    logic [31:0]                   exit_value;

    logic [7:0]  ref_mem [2 ** `MM_RAM_ADDR_WIDTH];
    exp_rsp_t    exp_q [$];
    logic [15:0] lfsr_state = 16'd56701;
    int unsigned edge_cnt = 0;
    int unsigned tmr_load_edge = 0;
    logic [31:0] tmr_load_val = '0;
    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          test_cnt = 0;
    int          test_err_start = 0;

    tb_clk_gen #(
        .PERIOD_NS  (20),
        .RST_CYCLES (4)
    ) clk_gen_i (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    mm_ram dut_i (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .instr_req_i     (instr_req),
        .instr_addr_i    (instr_addr),
        .instr_gnt_o     (instr_gnt),
        .instr_rvalid_o  (instr_rvalid),
        .instr_rdata_o   (instr_rdata),
        .data_req_i      (data_req),
        .data_pkt_i      (data_pkt),
        .data_gnt_o      (data_gnt),
        .data_rvalid_o   (data_rvalid),
        .data_rdata_o    (data_rdata),
        .data_err_o      (data_err),
        .irq_ack_i       (irq_ack),
        .irq_id_i        (irq_id),
        .irq_timer_o     (irq_timer),
        .console_valid_o (console_valid),
        .console_char_o  (console_char),
        .tests_passed_o  (tests_passed),
        .tests_failed_o  (tests_failed),
        .exit_valid_o    (exit_valid),
        .exit_value_o    (exit_value)
    );

    // number of rising edges seen so far
    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic check_value(input string name, input logic [127:0] act,
                               input logic [127:0] exp);
        chk_cnt++;
        if (act !== exp) begin
            $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, act, exp);
            err_cnt++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("%0t ns: timed out waiting for %s", $time, what);
        $display("Simulation failed");
        $finish;
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [31:0] rand_ram_addr();
        return 32'(REGION_BASE) + (rand_bits(6) << 2);
    endfunction

    function automatic data_req_t make_req(input logic [31:0] addr, input logic we,
                                           input logic [3:0] be, input logic [31:0] wdata);
        data_req_t req;
        req.addr  = addr;
        req.we    = we;
        req.be    = be;
        req.wdata = wdata;
        return req;
    endfunction

    // count held by the timer just before the given edge
    function automatic logic [31:0] timer_count_at(input int unsigned grant_edge);
        int unsigned steps;
        steps = grant_edge - tmr_load_edge - 1;
        if (tmr_load_val > steps) begin
            return tmr_load_val - steps;
        end
        return '0;
    endfunction

    // expected response of one request with the memory and timer model update
    function automatic exp_rsp_t ref_access(input data_req_t req, input int unsigned grant_edge);
        exp_rsp_t                      rsp;
        logic [`MM_RAM_ADDR_WIDTH-1:0] base;
        rsp            = '0;
        rsp.grant_edge = grant_edge;
        rsp.chk_data   = !req.we;
        base           = {req.addr[`MM_RAM_ADDR_WIDTH-1:2], 2'b00};
        if (req.addr < (32'd1 << `MM_RAM_ADDR_WIDTH)) begin
            for (int i = 0; i < 4; i++) begin
                rsp.rdata[8*i +: 8] = ref_mem[base + `MM_RAM_ADDR_WIDTH'(i)];
                if (req.we && req.be[i]) begin
                    ref_mem[base + `MM_RAM_ADDR_WIDTH'(i)] = req.wdata[8*i +: 8];
                end
            end
        end else if (!req.we && req.addr == `MM_TIMER_READ_ADDR) begin
            rsp.rdata = timer_count_at(grant_edge);
        end else if (req.we && req.addr == `MM_TIMER_MASK_ADDR) begin
            // a mask write holds the count for one edge
            tmr_load_val  = timer_count_at(grant_edge);
            tmr_load_edge = grant_edge;
        end else if (req.we && req.addr == `MM_TIMER_CNT_ADDR) begin
            tmr_load_val  = req.wdata;
            tmr_load_edge = grant_edge;
        end else if (!(req.we && (req.addr == `MM_CONSOLE_ADDR || req.addr == `MM_STATUS_ADDR
                                  || req.addr == `MM_EXIT_ADDR))) begin
            rsp.err      = 1'b1;
            rsp.chk_data = 1'b1;
        end
        return rsp;
    endfunction

    // response checker samples at the falling edge where outputs are stable
    always @(negedge clk) begin
        exp_rsp_t rsp;
        if (data_rvalid) begin
            if (exp_q.size() == 0) begin
                $display("%0t ns: data response without an outstanding request", $time);
                err_cnt++;
            end else begin
                rsp = exp_q.pop_front();
                check_value("data_rvalid_o edge", edge_cnt, rsp.grant_edge);
                check_value("data_err_o", data_err, rsp.err);
                if (rsp.chk_data) begin
                    check_value("data_rdata_o", data_rdata, rsp.rdata);
                end
            end
        end else if (exp_q.size() != 0 && exp_q[0].grant_edge < edge_cnt) begin
            $display("%0t ns: no data response one cycle after a grant", $time);
            err_cnt++;
            void'(exp_q.pop_front());
        end
    end

    task automatic issue_req(input data_req_t req);
        @(negedge clk);
        data_req = 1'b1;
        data_pkt = req;
        exp_q.push_back(ref_access(req, edge_cnt + 1));
        #1;
        check_value("data_gnt_o", data_gnt, 1'b1);
    endtask

    task automatic bus_idle();
        @(negedge clk);
        data_req = 1'b0;
        data_pkt = '0;
    endtask

    task automatic wait_responses();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            if (n == 50) begin
                abort_run("data responses");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1) begin
            if (n == 20) begin
                abort_run("reset release");
            end
            @(negedge clk);
            n++;
        end
    endtask

    // single peripheral write and its expected {console, passed, failed, exit} pulses
    task automatic write_periph(input logic [31:0] addr, input logic [31:0] wdata,
                                input logic [3:0] exp_pulse);
        issue_req(make_req(addr, 1'b1, 4'hf, wdata));
        bus_idle();
        check_value("{console_valid_o, tests_passed_o, tests_failed_o, exit_valid_o}",
                    {console_valid, tests_passed, tests_failed, exit_valid}, exp_pulse);
        if (exp_pulse[3]) begin
            check_value("console_char_o", console_char, wdata[7:0]);
        end
        if (exp_pulse[0]) begin
            check_value("exit_value_o", exit_value, wdata);
        end
        @(negedge clk);
        check_value("{console_valid_o, tests_passed_o, tests_failed_o, exit_valid_o}",
                    {console_valid, tests_passed, tests_failed, exit_valid}, 4'b0000);
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        $display("test %-16s done, %0d errors", name, err_cnt - test_err_start);
        test_err_start = err_cnt;
    endtask

    `include "tb_mm_ram_tests.svh"

    initial begin
        instr_req  = 1'b0;
        instr_addr = '0;
        data_req   = 1'b0;
        data_pkt   = '0;
        irq_ack    = 1'b0;
        irq_id     = '0;
        wait_reset();
        check_value("control outputs after reset",
                    {data_rvalid, instr_rvalid, console_valid, tests_passed,
                     tests_failed, exit_valid, irq_timer}, 7'd0);
        test_ram_access();
        test_instr_fetch();
        test_back_to_back();
        test_status_exit_console();
        test_timer();
        test_unmapped();
        $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+verilog
+incdir+dv
verilog/mem_bus_pkg.sv
verilog/periph_pkg.sv
verilog/dp_ram.sv
verilog/data_addr_decoder.sv
verilog/periph_regs.sv
verilog/data_rsp_ctrl.sv
verilog/mm_ram.sv
dv/tb_clk_gen.sv
dv/tb_mm_ram.sv
